/* cpu_pkg.sv */
package cpu_pkg;

  // datapath width
  localparam int WORD_W = 16;

  // instruction field widths
  localparam int OPCODE_W   = 4;
  localparam int REG_ADDR_W = 4;
  localparam int IMM4_W     = 4;
  localparam int IMM8_W     = 8;

  // store queue depth used by the top unless overridden
  localparam int DEFAULT_STORE_DEPTH = 4;

  // one data or address word
  typedef logic [WORD_W-1:0] word_t;

  // index into the sixteen entry register file
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // opcodes in bits 15..12
  // codes not listed here decode as no-operation
  typedef enum logic [OPCODE_W-1:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_XOR = 4'd2,
    OP_SLL = 4'd4,
    OP_SRA = 4'd5,
    OP_ROR = 4'd6,
    OP_SW  = 4'd9,
    OP_LLB = 4'd10,
    OP_LHB = 4'd11,
    OP_HLT = 4'd15
  } opcode_t;

  // wishbone write master states
  typedef enum logic {
    WB_IDLE,
    WB_BUSY
  } wb_state_t;

endpackage

/* alu.sv */
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::opcode_t op,
  output cpu_pkg::word_t   y
);
  import cpu_pkg::*;

  word_t      sum;
  word_t      diff;
  word_t      sat_val;
  logic       add_ovf;
  logic       sub_ovf;
  logic [3:0] shamt;

  // raw two's complement results
  assign sum  = a + b;
  assign diff = a - b;

  // add overflows when both inputs share a sign the result lost
  assign add_ovf = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
  // subtract overflows only for inputs of opposite sign
  assign sub_ovf = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);

  // overflow always goes toward the sign of a
  assign sat_val = a[WORD_W-1] ? 16'h8000 : 16'h7fff;

  // shift amount is the 4-bit immediate
  assign shamt = b[3:0];

  always_comb begin
    // no alu function means a passes through
    y = a;
    case (op)
      OP_ADD: y = add_ovf ? sat_val : sum;
      OP_SUB: y = sub_ovf ? sat_val : diff;
      OP_XOR: y = a ^ b;
      OP_SLL: y = a << shamt;
      OP_SRA: y = word_t'($signed(a) >>> shamt);
      // rotate right by the amount
      // a zero amount leaves the left shift empty
      OP_ROR: y = (a >> shamt) | (a << (WORD_W - shamt));
      // immediate byte lands low and the high byte is kept
      OP_LLB: y = {a[15:8], b[7:0]};
      // immediate byte lands high and the low byte is kept
      OP_LHB: y = {b[7:0], a[7:0]};
      default: y = a;
    endcase
  end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu_pkg::reg_addr_t rd_addr_a,
  input  cpu_pkg::reg_addr_t rd_addr_b,
  output cpu_pkg::word_t     rd_data_a,
  output cpu_pkg::word_t     rd_data_b,
  input  logic               wr_en,
  input  cpu_pkg::reg_addr_t wr_addr,
  input  cpu_pkg::word_t     wr_data
);
  import cpu_pkg::*;

  word_t regs [2**REG_ADDR_W];
  logic  wr_live;

  // register 0 never takes a write
  assign wr_live = wr_en && (wr_addr != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign rd_data_a = (wr_live && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
  assign rd_data_b = (wr_live && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

endmodule

/* cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
  input  logic           clk,
  input  logic           rst_n,
  output cpu_pkg::word_t imem_addr,
  input  cpu_pkg::word_t imem_data,
  output logic           st_valid,
  output cpu_pkg::word_t st_addr,
  output cpu_pkg::word_t st_data,
  input  logic           st_full,
  output logic           retired_halt
);
  import cpu_pkg::*;

  // pipe advances when no store is blocked in write-back
  logic en;

  // fetch
  word_t pc;
  logic  fetch_stop;

  // fetch/decode register
  logic  fd_valid;
  word_t fd_instr;

  // decode
  opcode_t           id_op;
  reg_addr_t         id_rd;
  reg_addr_t         id_src_a;
  reg_addr_t         id_src_b;
  logic [IMM4_W-1:0] id_imm4;
  logic [IMM8_W-1:0] id_imm8;
  word_t             id_data_a;
  word_t             id_data_b;
  word_t             id_imm;
  logic              id_use_imm;
  logic              id_wr;
  logic              id_store;
  logic              id_hlt;

  // decode/execute register
  logic      de_valid;
  opcode_t   de_op;
  reg_addr_t de_rd;
  reg_addr_t de_src_a;
  reg_addr_t de_src_b;
  word_t     de_a;
  word_t     de_b;
  word_t     de_imm;
  logic      de_use_imm;
  logic      de_wr;
  logic      de_store;
  logic      de_hlt;

  // execute
  word_t ex_a;
  word_t ex_b;
  word_t ex_alu_b;
  word_t ex_alu_y;
  word_t ex_result;

  // execute/write-back register
  logic      ew_valid;
  reg_addr_t ew_rd;
  word_t     ew_result;
  word_t     ew_data;
  logic      ew_wr;
  logic      ew_store;
  logic      ew_hlt;

  // back-pressure from the store queue freezes every stage
  assign en = !(ew_valid && ew_store && st_full);

  assign imem_addr = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= '0;
      fetch_stop <= 1'b0;
      fd_valid   <= 1'b0;
    end else if (en) begin
      // pc freezes once HLT shows up in decode
      if (!fetch_stop && !(fd_valid && id_hlt)) begin
        pc <= pc + 16'd2;
      end
      if (fd_valid && id_hlt) begin
        fetch_stop <= 1'b1;
      end
      // words after HLT never enter the pipe
      fd_valid <= !(fetch_stop || (fd_valid && id_hlt));
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      fd_instr <= imem_data;
    end
  end

  // field split
  assign id_op   = opcode_t'(fd_instr[15:12]);
  assign id_rd   = fd_instr[11:8];
  assign id_imm4 = fd_instr[3:0];
  assign id_imm8 = fd_instr[7:0];

  // LLB and LHB read rd itself and SW reads the register to store
  assign id_src_a = (id_op == OP_LLB || id_op == OP_LHB) ? id_rd : fd_instr[7:4];
  assign id_src_b = (id_op == OP_SW) ? id_rd : fd_instr[3:0];

  always_comb begin
    id_imm     = {{(WORD_W-IMM4_W){1'b0}}, id_imm4};
    id_use_imm = 1'b0;
    id_wr      = 1'b0;
    id_store   = 1'b0;
    id_hlt     = 1'b0;
    case (id_op)
      OP_ADD, OP_SUB, OP_XOR: id_wr = 1'b1;
      OP_SLL, OP_SRA, OP_ROR: begin
        id_wr      = 1'b1;
        id_use_imm = 1'b1;
      end
      OP_LLB, OP_LHB: begin
        id_wr      = 1'b1;
        id_use_imm = 1'b1;
        id_imm     = {{(WORD_W-IMM8_W){1'b0}}, id_imm8};
      end
      // word offset is sign extended and doubled
      OP_SW: begin
        id_store = 1'b1;
        id_imm   = {{(WORD_W-IMM4_W-1){id_imm4[IMM4_W-1]}}, id_imm4, 1'b0};
      end
      OP_HLT: id_hlt = 1'b1;
      default: id_wr = 1'b0;
    endcase
    // writes to register 0 are dropped here so forwarding skips them
    if (id_rd == '0) begin
      id_wr = 1'b0;
    end
  end

  register_file u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (id_src_a),
    .rd_addr_b (id_src_b),
    .rd_data_a (id_data_a),
    .rd_data_b (id_data_b),
    .wr_en     (ew_valid && ew_wr),
    .wr_addr   (ew_rd),
    .wr_data   (ew_result)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_valid <= 1'b0;
      ew_valid <= 1'b0;
    end else if (en) begin
      de_valid <= fd_valid;
      ew_valid <= de_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      de_op      <= id_op;
      de_rd      <= id_rd;
      de_src_a   <= id_src_a;
      de_src_b   <= id_src_b;
      de_a       <= id_data_a;
      de_b       <= id_data_b;
      de_imm     <= id_imm;
      de_use_imm <= id_use_imm;
      de_wr      <= id_wr;
      de_store   <= id_store;
      de_hlt     <= id_hlt;
    end
  end

  // forward the write-back result into execute
  assign ex_a = (ew_valid && ew_wr && (ew_rd == de_src_a)) ? ew_result : de_a;
  assign ex_b = (ew_valid && ew_wr && (ew_rd == de_src_b)) ? ew_result : de_b;
  assign ex_alu_b = de_use_imm ? de_imm : ex_b;

  alu u_alu (
    .a  (ex_a),
    .b  (ex_alu_b),
    .op (de_op),
    .y  (ex_alu_y)
  );

  // store address is a plain sum without saturation
  assign ex_result = de_store ? (ex_a + de_imm) : ex_alu_y;

  always_ff @(posedge clk) begin
    if (en) begin
      ew_rd     <= de_rd;
      ew_result <= ex_result;
      ew_data   <= ex_b;
      ew_wr     <= de_wr;
      ew_store  <= de_store;
      ew_hlt    <= de_hlt;
    end
  end

  // store goes out only when the queue has room
  assign st_valid = ew_valid && ew_store && !st_full;
  assign st_addr  = ew_result;
  assign st_data  = ew_data;

  // sticky once HLT leaves write-back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retired_halt <= 1'b0;
    end else if (en && ew_valid && ew_hlt) begin
      retired_halt <= 1'b1;
    end
  end

endmodule

/* store_queue.sv */
`timescale 1ns/1ps

module store_queue #(
  parameter int STORE_DEPTH = cpu_pkg::DEFAULT_STORE_DEPTH
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           push,
  input  cpu_pkg::word_t push_addr,
  input  cpu_pkg::word_t push_data,
  output logic           full,
  output logic           empty,
  output cpu_pkg::word_t head_addr,
  output cpu_pkg::word_t head_data,
  input  logic           pop
);
  import cpu_pkg::*;

  localparam int PTR_W = (STORE_DEPTH > 1) ? $clog2(STORE_DEPTH) : 1;
  localparam int CNT_W = $clog2(STORE_DEPTH + 1);

  word_t             addr_mem [STORE_DEPTH];
  word_t             data_mem [STORE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  assign full  = (count == CNT_W'(STORE_DEPTH));
  assign empty = (count == '0);

  // guard both sides so a stray request cannot corrupt the count
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(STORE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(STORE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count unchanged
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_mem[wr_ptr] <= push_addr;
      data_mem[wr_ptr] <= push_data;
    end
  end

  // oldest entry sits at the read pointer
  assign head_addr = addr_mem[rd_ptr];
  assign head_data = data_mem[rd_ptr];

endmodule

/* wb_store_master.sv */
`timescale 1ns/1ps

module wb_store_master (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           q_empty,
  input  cpu_pkg::word_t q_addr,
  input  cpu_pkg::word_t q_data,
  output logic           q_pop,
  output logic           idle,
  output logic           wb_cyc,
  output logic           wb_stb,
  output logic           wb_we,
  output cpu_pkg::word_t wb_adr,
  output cpu_pkg::word_t wb_dat_w,
  input  logic           wb_ack
);
  import cpu_pkg::*;

  wb_state_t state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= WB_IDLE;
    end else begin
      case (state)
        // start a write one cycle after the queue shows data
        WB_IDLE: if (!q_empty) state <= WB_BUSY;
        // ack ends the cycle and forces one idle cycle
        WB_BUSY: if (wb_ack) state <= WB_IDLE;
        default: state <= WB_IDLE;
      endcase
    end
  end

  // head entry is latched so address and data hold while waiting
  always_ff @(posedge clk) begin
    if (state == WB_IDLE && !q_empty) begin
      wb_adr   <= q_addr;
      wb_dat_w <= q_data;
    end
  end

  // cyc stb and we move together
  assign wb_cyc = (state == WB_BUSY);
  assign wb_stb = (state == WB_BUSY);
  assign wb_we  = (state == WB_BUSY);

  // entry leaves the queue on the ack edge
  assign q_pop = (state == WB_BUSY) && wb_ack;
  assign idle  = (state == WB_IDLE);

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
  parameter int STORE_DEPTH = cpu_pkg::DEFAULT_STORE_DEPTH
) (
  input  logic           clk,
  input  logic           rst_n,
  output cpu_pkg::word_t imem_addr,
  input  cpu_pkg::word_t imem_data,
  output logic           wb_cyc,
  output logic           wb_stb,
  output logic           wb_we,
  output cpu_pkg::word_t wb_adr,
  output cpu_pkg::word_t wb_dat_w,
  input  logic           wb_ack,
  output logic           halted
);
  import cpu_pkg::*;

  // core to queue
  logic  st_valid;
  word_t st_addr;
  word_t st_data;
  logic  st_full;
  logic  retired_halt;

  // queue to master
  logic  q_empty;
  word_t q_addr;
  word_t q_data;
  logic  q_pop;
  logic  master_idle;

  cpu_core u_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .st_valid     (st_valid),
    .st_addr      (st_addr),
    .st_data      (st_data),
    .st_full      (st_full),
    .retired_halt (retired_halt)
  );

  store_queue #(
    .STORE_DEPTH (STORE_DEPTH)
  ) u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (st_valid),
    .push_addr (st_addr),
    .push_data (st_data),
    .full      (st_full),
    .empty     (q_empty),
    .head_addr (q_addr),
    .head_data (q_data),
    .pop       (q_pop)
  );

  wb_store_master u_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .q_empty  (q_empty),
    .q_addr   (q_addr),
    .q_data   (q_data),
    .q_pop    (q_pop),
    .idle     (master_idle),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack)
  );

  // done once HLT retired and every store has been acked
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (retired_halt && q_empty && master_idle) begin
      halted <= 1'b1;
    end
  end

endmodule

/* cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions #(
  parameter int STORE_DEPTH = cpu_pkg::DEFAULT_STORE_DEPTH
) (
  input logic           clk,
  input logic           rst_n,
  input logic           wb_cyc,
  input logic           wb_stb,
  input logic           wb_ack,
  input cpu_pkg::word_t wb_adr,
  input cpu_pkg::word_t wb_dat_w,
  input logic           st_valid,
  input logic           st_full,
  input logic           q_pop
);

  // entries held in the queue, counted from the push and pop handshakes
  int occupancy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occupancy <= 0;
    end else begin
      occupancy <= occupancy + int'(st_valid) - int'(q_pop);
    end
  end

  // a strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb |-> wb_cyc)
    else $error("wishbone stb high outside a cycle");

  // request and payload hold until ack
  hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat_w)))
    else $error("wishbone request changed before ack");

  // one idle cycle after each ack
  idle_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_cyc && wb_ack) |=> !wb_cyc)
    else $error("wishbone cycle not dropped after ack");

  // core waits instead of pushing into a full queue
  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    st_valid |-> (occupancy < STORE_DEPTH))
    else $error("store pushed while queue full");

  // full flag agrees with the handshake count
  full_matches_count: assert property (@(posedge clk) disable iff (!rst_n)
    st_full == (occupancy == STORE_DEPTH))
    else $error("queue full flag does not match its occupancy");

endmodule

bind cpu_top cpu_assertions #(
  .STORE_DEPTH (STORE_DEPTH)
) u_checks (
  .clk      (clk),
  .rst_n    (rst_n),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_ack   (wb_ack),
  .wb_adr   (wb_adr),
  .wb_dat_w (wb_dat_w),
  .st_valid (st_valid),
  .st_full  (st_full),
  .q_pop    (q_pop)
);

/* cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  // program length and run limit
  localparam int PROG_LEN         = 200;
  localparam int ROM_WORDS        = 256;
  localparam int CYCLES_PER_INSTR = 8;
  localparam int TIMEOUT_CYCLES   = PROG_LEN * CYCLES_PER_INSTR + 500;
  // cycles that halted must stay high after it rises
  localparam int HOLD_CYCLES      = 20;

  logic  clk    = 1'b0;
  logic  rst_n  = 1'b0;
  logic  wb_ack = 1'b0;
  word_t imem_addr;
  word_t imem_data;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  word_t wb_adr;
  word_t wb_dat_w;
  logic  halted;

  // instruction rom and random state
  word_t  rom [ROM_WORDS];
  integer seed = 32'h3f5c_cdbc;

  // stores seen on the bus and stores the model predicts
  word_t obs_addr [$];
  word_t obs_data [$];
  word_t exp_addr [$];
  word_t exp_data [$];
  word_t hlt_addr;

  // slave timing for the current run
  int wait_cnt   = 0;
  int delay_min  = 0;
  int delay_span = 5;

  // run control and watchdog
  logic run_active = 1'b0;
  int   run_cycles = 0;
  int   full_cycles = 0;

  int word_errors;
  int count_errors;
  int bit_errors;
  int other_errors;

  always #4 clk = ~clk;

  // asynchronous rom read, word addressed
  assign imem_data = rom[imem_addr[8:1]];

  cpu_top #(
    .STORE_DEPTH (DEFAULT_STORE_DEPTH)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_ack    (wb_ack),
    .halted    (halted)
  );

  // wishbone slave with a random wait before each ack
  always @(posedge clk) begin
    if (!rst_n) begin
      wb_ack   <= 1'b0;
      wait_cnt <= 0;
    end else if (wb_ack) begin
      // ack lasts one cycle, the write completes here
      wb_ack <= 1'b0;
      if (wb_cyc && wb_we) begin
        obs_addr.push_back(wb_adr);
        obs_data.push_back(wb_dat_w);
      end
    end else if (wb_cyc && wb_stb) begin
      if (wait_cnt == 0) begin
        wb_ack <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end else begin
      wait_cnt <= delay_min + {$random(seed)} % (delay_span + 1);
    end
  end

  // watchdog counts only while a run waits for halted
  always @(posedge clk) begin
    if (!run_active) begin
      run_cycles = 0;
    end else begin
      run_cycles = run_cycles + 1;
      if (run_cycles > TIMEOUT_CYCLES) begin
        $display("timeout: halted did not rise within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  // back-pressure monitor
  always @(negedge clk) begin
    if (run_active && dut_i.st_full) begin
      full_cycles = full_cycles + 1;
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      word_errors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      count_errors++;
      $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errors++;
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic word_t encode(input logic [3:0] op, input logic [3:0] f1,
                                   input logic [3:0] f2, input logic [3:0] f3);
    return {op, f1, f2, f3};
  endfunction

  // one random instruction, SW weighted by the program kind
  function automatic word_t random_instr(input logic store_heavy);
    int         sel;
    int         kind;
    word_t      f;
    logic [3:0] nop_ops [6];
    nop_ops = '{4'h3, 4'h7, 4'h8, 4'hc, 4'hd, 4'he};
    sel  = {$random(seed)} % 16;
    kind = {$random(seed)} % 10;
    f    = $random(seed);
    if (sel < (store_heavy ? 14 : 4)) begin
      return encode(OP_SW, f[11:8], f[7:4], f[3:0]);
    end
    case (kind)
      0: return encode(OP_LLB, f[11:8], f[7:4], f[3:0]);
      1: return encode(OP_LHB, f[11:8], f[7:4], f[3:0]);
      // unused opcodes behave as no-operation
      2: return encode(nop_ops[f[15:12] % 6], f[11:8], f[7:4], f[3:0]);
      3: return encode(OP_ADD, f[11:8], f[7:4], f[3:0]);
      4: return encode(OP_SUB, f[11:8], f[7:4], f[3:0]);
      5: return encode(OP_XOR, f[11:8], f[7:4], f[3:0]);
      6: return encode(OP_SLL, f[11:8], f[7:4], f[3:0]);
      7: return encode(OP_SRA, f[11:8], f[7:4], f[3:0]);
      8: return encode(OP_ROR, f[11:8], f[7:4], f[3:0]);
      default: return encode(OP_ADD, f[11:8], f[7:4], f[3:0]);
    endcase
  endfunction

  task automatic build_program(input logic store_heavy);
    int    i;
    int    r;
    word_t w;
    // padding encodes its own index so no two rom words match
    for (i = 0; i < ROM_WORDS; i++) begin
      rom[i] = {4'h3, i[11:0]};
    end
    i = 0;
    // seed r1..r15 with LLB/LHB pairs
    for (r = 1; r < 16; r++) begin
      w = $random(seed);
      rom[i] = encode(OP_LLB, r[3:0], w[7:4], w[3:0]);
      i++;
      rom[i] = encode(OP_LHB, r[3:0], w[15:12], w[11:8]);
      i++;
    end
    while (i < PROG_LEN - 1) begin
      rom[i] = random_instr(store_heavy);
      i++;
    end
    rom[i] = encode(OP_HLT, 4'h0, 4'h0, 4'h0);
  endtask

  function automatic word_t sat_add(input word_t a, input word_t b);
    int s;
    s = $signed(a) + $signed(b);
    if (s > 32767) return 16'h7fff;
    if (s < -32768) return 16'h8000;
    return s[15:0];
  endfunction

  function automatic word_t sat_sub(input word_t a, input word_t b);
    int s;
    s = $signed(a) - $signed(b);
    if (s > 32767) return 16'h7fff;
    if (s < -32768) return 16'h8000;
    return s[15:0];
  endfunction

  function automatic word_t shift_right_arith(input word_t a, input logic [3:0] sh);
    word_t r;
    r = a;
    repeat (sh) r = {r[15], r[15:1]};
    return r;
  endfunction

  function automatic word_t rotate_right(input word_t a, input logic [3:0] sh);
    logic [31:0] dbl;
    dbl = {a, a} >> sh;
    return dbl[15:0];
  endfunction

  // in-order reference execution of the rom
  task automatic run_model;
    word_t      regs [16];
    int         idx;
    logic       done;
    logic       wr;
    word_t      instr;
    logic [3:0] op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
    word_t      res;
    word_t      off;
    for (int k = 0; k < 16; k++) begin
      regs[k] = '0;
    end
    exp_addr.delete();
    exp_data.delete();
    idx  = 0;
    done = 1'b0;
    while (!done && idx < ROM_WORDS) begin
      instr = rom[idx];
      op    = instr[15:12];
      rd    = instr[11:8];
      rs    = instr[7:4];
      rt    = instr[3:0];
      wr    = 1'b1;
      res   = '0;
      case (op)
        OP_ADD: res = sat_add(regs[rs], regs[rt]);
        OP_SUB: res = sat_sub(regs[rs], regs[rt]);
        OP_XOR: res = regs[rs] ^ regs[rt];
        OP_SLL: res = regs[rs] << rt;
        OP_SRA: res = shift_right_arith(regs[rs], rt);
        OP_ROR: res = rotate_right(regs[rs], rt);
        OP_LLB: res = {regs[rd][15:8], instr[7:0]};
        OP_LHB: res = {instr[7:0], regs[rd][7:0]};
        OP_SW: begin
          // byte offset is the signed word offset times two
          off = {{12{rt[3]}}, rt};
          off = off << 1;
          exp_addr.push_back(regs[rs] + off);
          exp_data.push_back(regs[rd]);
          wr = 1'b0;
        end
        OP_HLT: begin
          hlt_addr = word_t'(idx * 2);
          done     = 1'b1;
          wr       = 1'b0;
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 4'h0) begin
        regs[rd] = res;
      end
      idx++;
    end
  endtask

  task automatic apply_reset;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic execute_run(input string label, input logic expect_full);
    int n;
    int full_before;
    obs_addr.delete();
    obs_data.delete();
    apply_reset();
    @(negedge clk);
    check_bit({label, " halted after reset"}, halted, 1'b0);
    full_before = full_cycles;
    run_active  = 1'b1;
    while (!halted) @(negedge clk);
    run_active = 1'b0;
    // every predicted store must be acked before halted
    check_count({label, " stores at halt"}, obs_addr.size(), exp_addr.size());
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_bit({label, " halted"}, halted, 1'b1);
    end
    check_word({label, " imem_addr"}, imem_addr, hlt_addr + 16'd2);
    // padding after HLT must add nothing
    check_count({label, " store count"}, obs_addr.size(), exp_addr.size());
    n = (obs_addr.size() < exp_addr.size()) ? obs_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      check_word($sformatf("%s wb_adr[%0d]", label, i), obs_addr[i], exp_addr[i]);
      check_word($sformatf("%s wb_dat_w[%0d]", label, i), obs_data[i], exp_data[i]);
    end
    if (expect_full && full_cycles == full_before) begin
      other_errors++;
      $display("%s: the store queue never filled, back-pressure was not exercised", label);
    end
  endtask

  initial begin
    word_errors  = 0;
    count_errors = 0;
    bit_errors   = 0;
    other_errors = 0;

    // mixed program with short ack waits
    build_program(1'b0);
    run_model();
    delay_min  = 0;
    delay_span = 5;
    execute_run("random", 1'b0);

    // mostly stores with long ack waits so the queue backs up
    build_program(1'b1);
    run_model();
    delay_min  = 3;
    delay_span = 5;
    execute_run("store burst", 1'b1);

    $display("summary: %0d word errors, %0d count errors, %0d bit errors, %0d other errors",
             word_errors, count_errors, bit_errors, other_errors);
    if (word_errors + count_errors + bit_errors + other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
cpu_pkg.sv
alu.sv
register_file.sv
cpu_core.sv
store_queue.sv
wb_store_master.sv
cpu_top.sv
cpu_assertions.sv
cpu_tb.sv
